// File: Bender.yml
package:
  name: ising_cfg

sources:
  - files:
      - design/ising_cfg_pkg.sv
      - design/step_counter.sv
      - design/spin_row_mem.sv
      - design/analog_cfg.sv
      - design/ising_cfg_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/ising_cfg_assert.sv
      - tests/tb_ising_cfg.sv

// File: design/analog_cfg.sv
// weight transfer sequencer
// reads h then every J row, drives wordlines and the bitline register
// pulse timing and word stepping through two step counters
`default_nettype none

module analog_cfg (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,
    input  wire logic                                en_i,
    input  wire logic                                cfg_load_i,
    input  wire ising_cfg_pkg::cfg_t                 cfg_i,
    input  wire logic                                start_i,
    output logic                                     j_ren_o,
    output logic      [ising_cfg_pkg::J_ADDR_W-1:0]  j_raddr_o,
    input  wire ising_cfg_pkg::j_word_t              j_rdata_i,
    output logic                                     h_ren_o,
    input  wire ising_cfg_pkg::spin_row_t            h_rdata_i,
    output ising_cfg_pkg::array_drive_t              drive_o,
    output logic                                     idle_o
);
    logic                                busy_q;
    logic                                first_rd_q;
    logic                                h_ren_q;
    logic [ising_cfg_pkg::SEL_W-1:0]     sel_q;
    logic [ising_cfg_pkg::SEL_W-1:0]     sel_nxt;
    logic [ising_cfg_pkg::J_ADDR_W:0]    rd_ptr_q;
    logic                                start_ok;
    logic                                hold_ov;
    logic                                row_done;
    logic                                j_active;
    logic                                wl_active;
    logic                                last_slice;
    logic                                word_end;
    logic                                more_words;
    logic                                seq_ren;
    ising_cfg_pkg::spin_row_t            j_slice;
    ising_cfg_pkg::array_drive_t         drive_q;

    assign start_ok  = start_i & ~busy_q;
    assign j_active  = |drive_q.j_wwl;
    assign wl_active = drive_q.h_wwl | j_active;
    assign idle_o    = ~busy_q;
    assign drive_o   = drive_q;

    // sel_q names the slice latched at the next hold overflow
    assign last_slice = (sel_q == ising_cfg_pkg::SEL_W'(ising_cfg_pkg::PARALLELISM - 1));
    assign sel_nxt    = last_slice ? '0 : sel_q + 1'b1;
    assign j_slice    = j_rdata_i[sel_q * ising_cfg_pkg::ROW_W +: ising_cfg_pkg::ROW_W];

    // shown row is the final slice of its word when sel_q has wrapped
    assign word_end = j_active & hold_ov & (sel_q == '0);

    // prefetch: next word replaces rdata as the final slice goes to wbl
    assign more_words = (rd_ptr_q != (ising_cfg_pkg::J_ADDR_W + 1)'(ising_cfg_pkg::J_DEPTH));
    assign seq_ren    = wl_active & hold_ov & last_slice & more_words;

    // h and word 0 are fetched together, one cycle after start
    assign h_ren_o   = en_i & busy_q & first_rd_q;
    assign j_ren_o   = h_ren_o | seq_ren;
    assign j_raddr_o = rd_ptr_q[ising_cfg_pkg::J_ADDR_W-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            first_rd_q <= 1'b0;
            h_ren_q    <= 1'b0;
            sel_q      <= '0;
            rd_ptr_q   <= '0;
            drive_q    <= '0;
        end else if (!en_i) begin
            // abort, counters hold on their own
            busy_q     <= 1'b0;
            first_rd_q <= 1'b0;
            h_ren_q    <= 1'b0;
            drive_q    <= '0;
        end else if (start_ok) begin
            busy_q     <= 1'b1;
            first_rd_q <= 1'b1;
            sel_q      <= '0;
            rd_ptr_q   <= '0;
        end else begin
            first_rd_q <= 1'b0;
            h_ren_q    <= h_ren_o;
            if (j_ren_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (h_ren_q) begin
                drive_q.h_wwl <= 1'b1;
                drive_q.wbl   <= h_rdata_i;
            end else if (row_done) begin
                busy_q  <= 1'b0;
                drive_q <= '0;
            end else if (hold_ov && wl_active) begin
                // h hands over to J row 0, J rows shift up one
                drive_q.h_wwl <= 1'b0;
                drive_q.j_wwl <= drive_q.h_wwl ? (ising_cfg_pkg::NUM_SPIN)'(1)
                                               : drive_q.j_wwl << 1;
                drive_q.wbl   <= j_slice;
                sel_q         <= sel_nxt;
            end
        end
    end

    // write pulse length, restarted when the h row arrives
    step_counter u_cnt_hold (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .d_i        (cfg_i.cycle_per_write),
        .recount_i  (h_ren_q),
        .step_i     (wl_active),
        .q_o        (),
        .overflow_o (hold_ov)
    );

    // J words left, loaded at each start
    step_counter u_cnt_row (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (start_ok),
        .d_i        (ising_cfg_pkg::COUNTER_W'(ising_cfg_pkg::J_DEPTH)),
        .recount_i  (1'b0),
        .step_i     (word_end),
        .q_o        (),
        .overflow_o (row_done)
    );

endmodule

`default_nettype wire

// File: design/ising_cfg_pkg.sv
// array geometry and J/h memory sizes
// host address map and counter width
// packed row, word, host write, timing and array drive types
`default_nettype none

package ising_cfg_pkg;

    // spin array geometry
    localparam int NUM_SPIN    = 8;
    localparam int BITDATA     = 4;
    localparam int PARALLELISM = 2;
    localparam int ROW_W       = NUM_SPIN * BITDATA;

    // one J memory word carries PARALLELISM rows
    localparam int J_DEPTH  = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_W = 2;
    localparam int SEL_W    = (PARALLELISM > 1) ? $clog2(PARALLELISM) : 1;

    // host map: J words first, h row right above them
    localparam int HADDR       = J_DEPTH;
    localparam int HOST_ADDR_W = 3;

    localparam int COUNTER_W = 16;

    typedef struct packed {
        logic [NUM_SPIN-1:0][BITDATA-1:0] w;
    } spin_row_t;

    // slice 0 sits in the low bits
    typedef struct packed {
        spin_row_t [PARALLELISM-1:0] slice;
    } j_word_t;

    typedef struct packed {
        logic                   we;
        logic [HOST_ADDR_W-1:0] addr;
        j_word_t                data;
    } host_wr_t;

    typedef struct packed {
        logic [COUNTER_W-1:0] cycle_per_write;
    } cfg_t;

    typedef struct packed {
        logic                h_wwl;
        logic [NUM_SPIN-1:0] j_wwl;
        spin_row_t           wbl;
    } array_drive_t;

endpackage

`default_nettype wire

// File: design/ising_cfg_top.sv
// weight-loading top level
// host write decode into the J and h row memories
// four-phase start handshake around the sequencer
`default_nettype none

module ising_cfg_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        en_i,
    input  wire logic                        cfg_load_i,
    input  wire ising_cfg_pkg::cfg_t         cfg_i,
    input  wire ising_cfg_pkg::host_wr_t     host_wr_i,
    input  wire logic                        start_req_i,
    output logic                             start_ack_o,
    output logic                             idle_o,
    output ising_cfg_pkg::array_drive_t      drive_o
);
    logic                                  j_we;
    logic                                  h_we;
    logic                                  start_fire;
    logic                                  start_q;
    logic                                  req_seen_q;
    logic                                  ack_q;
    logic                                  idle_q;
    logic                                  j_ren;
    logic [ising_cfg_pkg::J_ADDR_W-1:0]    j_raddr;
    ising_cfg_pkg::j_word_t                j_rdata;
    logic                                  h_ren;
    ising_cfg_pkg::spin_row_t              h_rdata;

    // J words below HADDR, h row at HADDR, the rest ignored
    assign j_we = host_wr_i.we &
                  (host_wr_i.addr < ising_cfg_pkg::HOST_ADDR_W'(ising_cfg_pkg::HADDR));
    assign h_we = host_wr_i.we &
                  (host_wr_i.addr == ising_cfg_pkg::HOST_ADDR_W'(ising_cfg_pkg::HADDR));

    // one start per request, req must drop before the next one
    assign start_fire  = start_req_i & ~req_seen_q & ~ack_q & idle_o;
    assign start_ack_o = ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q    <= 1'b0;
            req_seen_q <= 1'b0;
            ack_q      <= 1'b0;
            idle_q     <= 1'b1;
        end else begin
            idle_q     <= idle_o;
            start_q    <= start_fire;
            req_seen_q <= start_req_i & (req_seen_q | start_fire);
            if (ack_q && !start_req_i) begin
                ack_q <= 1'b0;
            end else if (req_seen_q && idle_o && !idle_q) begin
                // sequencer just went back to idle
                ack_q <= 1'b1;
            end
        end
    end

    spin_row_mem #(
        .payload_t (ising_cfg_pkg::j_word_t),
        .DEPTH     (ising_cfg_pkg::J_DEPTH),
        .ADDR_W    (ising_cfg_pkg::J_ADDR_W)
    ) u_j_mem (
        .clk_i   (clk_i),
        .we_i    (j_we),
        .waddr_i (host_wr_i.addr[ising_cfg_pkg::J_ADDR_W-1:0]),
        .wdata_i (host_wr_i.data),
        .re_i    (j_ren),
        .raddr_i (j_raddr),
        .rdata_o (j_rdata)
    );

    // h row comes in on slice 0 of the host data
    spin_row_mem #(
        .payload_t (ising_cfg_pkg::spin_row_t),
        .DEPTH     (1)
    ) u_h_mem (
        .clk_i   (clk_i),
        .we_i    (h_we),
        .waddr_i (1'b0),
        .wdata_i (host_wr_i.data.slice[0]),
        .re_i    (h_ren),
        .raddr_i (1'b0),
        .rdata_o (h_rdata)
    );

    analog_cfg u_analog_cfg (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .cfg_load_i (cfg_load_i),
        .cfg_i      (cfg_i),
        .start_i    (start_q),
        .j_ren_o    (j_ren),
        .j_raddr_o  (j_raddr),
        .j_rdata_i  (j_rdata),
        .h_ren_o    (h_ren),
        .h_rdata_i  (h_rdata),
        .drive_o    (drive_o),
        .idle_o     (idle_o)
    );

endmodule

`default_nettype wire

// File: design/spin_row_mem.sv
// register-array row memory
// synchronous write port, registered read port
// payload type set per instance
`default_nettype none

module spin_row_mem #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter int  ADDR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire logic              clk_i,
    input  wire logic              we_i,
    input  wire logic [ADDR_W-1:0] waddr_i,
    input  wire payload_t          wdata_i,
    input  wire logic              re_i,
    input  wire logic [ADDR_W-1:0] raddr_i,
    output payload_t               rdata_o
);
    payload_t mem_q [DEPTH];

    // addresses past DEPTH are dropped
    always_ff @(posedge clk_i) begin
        if (we_i && (int'(waddr_i) < DEPTH)) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data holds until the next enable
    always_ff @(posedge clk_i) begin
        if (re_i && (int'(raddr_i) < DEPTH)) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: design/step_counter.sv
// loadable down-counter with recount
// flags the step that completes a period and reloads itself
`default_nettype none

module step_counter (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_i,
    input  wire logic                                 en_i,
    input  wire logic                                 load_i,
    input  wire logic [ising_cfg_pkg::COUNTER_W-1:0]  d_i,
    input  wire logic                                 recount_i,
    input  wire logic                                 step_i,
    output logic      [ising_cfg_pkg::COUNTER_W-1:0]  q_o,
    output logic                                      overflow_o
);
    logic [ising_cfg_pkg::COUNTER_W-1:0] reload_q;
    logic [ising_cfg_pkg::COUNTER_W-1:0] cnt_q;
    logic                                step;

    assign step = en_i & step_i;
    // last step of a period, the count would hit zero
    assign overflow_o = step & (cnt_q <= 'd1);
    assign q_o = cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reload_q <= '0;
            cnt_q    <= '0;
        end else if (load_i) begin
            reload_q <= d_i;
            cnt_q    <= d_i;
        end else if (en_i && recount_i) begin
            cnt_q <= reload_q;
        end else if (overflow_o) begin
            cnt_q <= reload_q;
        end else if (step) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
design/ising_cfg_pkg.sv
design/step_counter.sv
design/spin_row_mem.sv
design/analog_cfg.sv
design/ising_cfg_top.sv
tests/tb_clk_gen.sv
tests/ising_cfg_assert.sv
tests/tb_ising_cfg.sv

// File: tests/ising_cfg_assert.sv
// concurrent checks on the sequencer outputs
// J wordlines one-hot, h and J exclusive, no wordline while idle
// bound into every analog_cfg instance
`default_nettype none

module ising_cfg_assert (
    input wire logic                        clk_i,
    input wire logic                        rst_i,
    input wire ising_cfg_pkg::array_drive_t drive_i,
    input wire logic                        idle_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertion count
    int fail_cnt = 0;

    a_j_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(drive_i.j_wwl))
    else begin
        $error("J wordlines not one-hot: %b", drive_i.j_wwl);
        fail_cnt++;
    end

    a_h_j_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(drive_i.h_wwl && (drive_i.j_wwl != '0)))
    else begin
        $error("h and J wordlines high together");
        fail_cnt++;
    end

    a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !(idle_i && (drive_i.h_wwl || (drive_i.j_wwl != '0))))
    else begin
        $error("wordline high while idle");
        fail_cnt++;
    end

endmodule

bind analog_cfg ising_cfg_assert u_assert (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .drive_i (drive_o),
    .idle_i  (idle_o)
);

`default_nettype wire

// File: tests/tb_clk_gen.sv
// clock and reset source for the testbench
// 100 ns period, reset held for the first two rising edges
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // release just after the second edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_ising_cfg.sv
// testbench for the weight-loading path
// random J and h contents, table of pulse lengths and enable drops
// segment monitor on the wordlines, handshake and timing checks
// cycle-count timeout and a closing summary
`default_nettype none

module tb_ising_cfg;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        int cpw;
        int drop;
        int segs;
    } test_row_t;

    logic                        clk_i;
    logic                        rst_i;
    logic                        en_i;
    logic                        cfg_load_i;
    logic                        start_req_i;
    logic                        start_ack_o;
    logic                        idle_o;
    ising_cfg_pkg::cfg_t         cfg_i;
    ising_cfg_pkg::host_wr_t     host_wr_i;
    ising_cfg_pkg::array_drive_t drive_o;

    test_row_t                   table_q[$];
    ising_cfg_pkg::spin_row_t    exp_h;
    ising_cfg_pkg::j_word_t      exp_j [ising_cfg_pkg::J_DEPTH];
    ising_cfg_pkg::array_drive_t seg_drive[$];
    int                          seg_len[$];
    logic                        seg_open;
    int                          err_cnt = 0;
    int                          test_err = 0;
    int                          pass_cnt = 0;
    int                          assert_cnt = 0;
    int                          cycle_cnt = 0;
    int                          cycle_limit = 0;

    tb_clk_gen u_clk_gen (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    ising_cfg_top u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .cfg_load_i  (cfg_load_i),
        .cfg_i       (cfg_i),
        .host_wr_i   (host_wr_i),
        .start_req_i (start_req_i),
        .start_ack_o (start_ack_o),
        .idle_o      (idle_o),
        .drive_o     (drive_o)
    );

    // one segment per steady wordline and bitline pattern
    always @(negedge clk_i) begin
        if (drive_o.h_wwl || (drive_o.j_wwl != '0)) begin
            if (seg_open && (drive_o == seg_drive[seg_drive.size() - 1])) begin
                seg_len[seg_len.size() - 1] += 1;
            end else begin
                seg_drive.push_back(drive_o);
                seg_len.push_back(1);
                seg_open = 1'b1;
            end
        end else begin
            seg_open = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_val(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail at %0t: %s, expected %0h, got %0h", $time, what, exp, act);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic load_cfg(input int cpw);
        cfg_load_i            = 1'b1;
        cfg_i.cycle_per_write = ising_cfg_pkg::COUNTER_W'(cpw);
        tick();
        cfg_load_i = 1'b0;
    endtask

    task automatic host_write(input int addr, input ising_cfg_pkg::j_word_t data);
        host_wr_i.we   = 1'b1;
        host_wr_i.addr = ising_cfg_pkg::HOST_ADDR_W'(addr);
        host_wr_i.data = data;
        tick();
        host_wr_i.we = 1'b0;
    endtask

    // J words, then h, then addresses that must be ignored
    task automatic fill_mems();
        ising_cfg_pkg::j_word_t word;
        for (int a = 0; a < 2 ** ising_cfg_pkg::HOST_ADDR_W; a++) begin
            for (int s = 0; s < ising_cfg_pkg::PARALLELISM; s++) begin
                word.slice[s] = ising_cfg_pkg::spin_row_t'($urandom);
            end
            if (a < ising_cfg_pkg::J_DEPTH) begin
                exp_j[a] = word;
            end else if (a == ising_cfg_pkg::HADDR) begin
                exp_h = word.slice[0];
            end
            host_write(a, word);
        end
    endtask

    task automatic clear_segments();
        seg_drive.delete();
        seg_len.delete();
        seg_open = 1'b0;
    endtask

    // h first, then J row r from word r / PARALLELISM, slice r % PARALLELISM
    task automatic check_segments(input int segs, input int cpw, input int last_len);
        int                          row;
        ising_cfg_pkg::array_drive_t exp_d;
        check_val("segment count", segs, seg_drive.size());
        for (int k = 0; (k < segs) && (k < seg_drive.size()); k++) begin
            row   = k - 1;
            exp_d = '0;
            if (k == 0) begin
                exp_d.h_wwl = 1'b1;
                exp_d.wbl   = exp_h;
            end else begin
                exp_d.j_wwl[row] = 1'b1;
                exp_d.wbl = exp_j[row / ising_cfg_pkg::PARALLELISM]
                                .slice[row % ising_cfg_pkg::PARALLELISM];
            end
            check_val($sformatf("segment %0d wordlines", k),
                      {exp_d.h_wwl, exp_d.j_wwl}, {seg_drive[k].h_wwl, seg_drive[k].j_wwl});
            check_val($sformatf("segment %0d bitlines", k), exp_d.wbl, seg_drive[k].wbl);
            check_val($sformatf("segment %0d length", k),
                      (k == segs - 1) ? last_len : cpw, seg_len[k]);
        end
    endtask

    // ack must come exactly one cycle after idle rises
    task automatic wait_ack();
        int idle_run;
        idle_run = 0;
        while (!start_ack_o) begin
            idle_run = idle_o ? idle_run + 1 : 0;
            tick();
        end
        check_val("idle cycles before ack", 1, idle_run);
        check_val("idle at ack", 1, idle_o);
        check_val("segment still open at ack", 0, seg_open);
    endtask

    task automatic release_req();
        start_req_i = 1'b0;
        tick();
        check_val("ack after req drop", 0, start_ack_o);
    endtask

    task automatic run_transfer(input int cpw, input int segs);
        clear_segments();
        start_req_i = 1'b1;
        wait_ack();
        check_segments(segs, cpw, cpw);
        // held request must not start a second transfer
        repeat (4) begin
            tick();
            check_val("ack while req held", 1, start_ack_o);
            check_val("idle while req held", 1, idle_o);
            check_val("drive while req held", 0, drive_o);
        end
        release_req();
    endtask

    task automatic run_abort(input int cpw, input int drop, input int segs);
        clear_segments();
        start_req_i = 1'b1;
        do begin
            tick();
        end while (!drive_o.h_wwl);
        repeat (drop) tick();
        en_i = 1'b0;
        tick();
        check_val("drive after enable drop", 0, drive_o);
        check_val("idle after enable drop", 1, idle_o);
        check_val("ack right after enable drop", 0, start_ack_o);
        wait_ack();
        release_req();
        en_i = 1'b1;
        check_segments(segs, cpw, drop + 1 - (segs - 1) * cpw);
    endtask

    initial begin
        en_i        = 1'b1;
        cfg_load_i  = 1'b0;
        cfg_i       = '0;
        host_wr_i   = '0;
        start_req_i = 1'b0;
        seg_open    = 1'b0;
        void'($urandom(32'h9dc7_3022));

        // cycle_per_write, en drop cycle (-1 none), rows shown incl. h
        table_q.push_back('{1, -1, 9});
        table_q.push_back('{3, -1, 9});
        table_q.push_back('{7, -1, 9});
        table_q.push_back('{3, 10, 4});
        table_q.push_back('{2, 0, 1});
        table_q.push_back('{1, 5, 6});
        foreach (table_q[i]) begin
            cycle_limit += (ising_cfg_pkg::NUM_SPIN + 1) * (table_q[i].cpw + 4);
        end
        cycle_limit += 100 * table_q.size();

        do begin
            @(posedge clk_i);
        end while (rst_i);
        #1;
        check_val("idle after reset", 1, idle_o);
        check_val("ack after reset", 0, start_ack_o);
        check_val("drive after reset", 0, drive_o);
        $display("reset: %0d errors", test_err);

        foreach (table_q[i]) begin
            test_err = 0;
            load_cfg(table_q[i].cpw);
            fill_mems();
            if (table_q[i].drop >= 0) begin
                run_abort(table_q[i].cpw, table_q[i].drop, table_q[i].segs);
                run_transfer(table_q[i].cpw, ising_cfg_pkg::NUM_SPIN + 1);
            end else begin
                run_transfer(table_q[i].cpw, table_q[i].segs);
            end
            if (test_err == 0) begin
                pass_cnt++;
            end
            $display("test %0d: cycle_per_write %0d, en drop %s, %0d errors", i,
                     table_q[i].cpw,
                     (table_q[i].drop < 0) ? "none" : $sformatf("%0d", table_q[i].drop),
                     test_err);
        end

        assert_cnt = u_dut.u_analog_cfg.u_assert.fail_cnt;
        $display("summary: %0d of %0d tests clean, %0d check errors, %0d assertion failures",
                 pass_cnt, table_q.size(), err_cnt, assert_cnt);
        if ((err_cnt == 0) && (assert_cnt == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
